// ==== logic/bram_wrapper.sv ====
`timescale 1ns/10ps
`default_nettype none

module bram_wrapper (
	input  logic                clk,
	input  logic                arst_n,

	// Read address channel
	input  nn_mem_pkg::rd_req_t rd_addr,
	input  logic                rd_addr_valid,
	output logic                rd_addr_ready,

	// Read data channel
	output nn_mem_pkg::word_t   rd_data,
	output logic                rd_data_valid,
	input  logic                rd_data_ready,

	// Write address channel
	input  nn_mem_pkg::addr_t   wr_addr,
	input  logic                wr_addr_valid,
	output logic                wr_addr_ready,

	// Write data channel
	input  nn_mem_pkg::word_t   wr_data,
	input  logic                wr_data_valid,
	output logic                wr_data_ready
);

	// Weight storage, undefined until written
	nn_mem_pkg::word_t mem [0:nn_mem_pkg::DEPTH-1];

	////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////

	// Accepted address waiting for the array access
	nn_mem_pkg::addr_t rd_addr_q;
	logic              rd_pend;

	// Output word and its valid flag
	nn_mem_pkg::word_t rd_data_q;
	logic              rd_data_valid_q;

	logic rd_addr_fire;
	logic rd_data_fire;

	// One read in flight, address side closed until the word leaves
	assign rd_addr_ready = !rd_pend && !rd_data_valid_q;
	assign rd_addr_fire  = rd_addr_valid && rd_addr_ready;
	assign rd_data_fire  = rd_data_valid_q && rd_data_ready;

	assign rd_data       = rd_data_q;
	assign rd_data_valid = rd_data_valid_q;

	// Pending and valid flags
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_pend         <= 1'b0;
			rd_data_valid_q <= 1'b0;
		end else begin
			if (rd_addr_fire) begin
				rd_pend <= 1'b1;
			end else if (rd_pend) begin
				rd_pend <= 1'b0;
			end

			// Array read lands one edge after the address
			if (rd_pend) begin
				rd_data_valid_q <= 1'b1;
			end else if (rd_data_fire) begin
				rd_data_valid_q <= 1'b0;
			end
		end
	end

	// Address capture and array read
	always_ff @(posedge clk) begin
		if (rd_addr_fire) begin
			rd_addr_q <= rd_addr.addr;
		end
		if (rd_pend) begin
			rd_data_q <= mem[rd_addr_q];
		end
	end

	////////////////////////////////////////////////////////////
	// Write path
	////////////////////////////////////////////////////////////

	// Holding registers, one per write channel
	nn_mem_pkg::addr_t wr_addr_q;
	nn_mem_pkg::word_t wr_data_q;
	logic              wr_addr_full;
	logic              wr_data_full;

	// Both halves present, commit on this edge
	logic wr_commit;

	assign wr_addr_ready = !wr_addr_full;
	assign wr_data_ready = !wr_data_full;
	assign wr_commit     = wr_addr_full && wr_data_full;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_addr_full <= 1'b0;
			wr_data_full <= 1'b0;
		end else if (wr_commit) begin
			wr_addr_full <= 1'b0;
			wr_data_full <= 1'b0;
		end else begin
			if (wr_addr_valid && wr_addr_ready) begin
				wr_addr_full <= 1'b1;
			end
			if (wr_data_valid && wr_data_ready) begin
				wr_data_full <= 1'b1;
			end
		end
	end

	// Holding register loads and the array write
	always_ff @(posedge clk) begin
		if (wr_addr_valid && wr_addr_ready) begin
			wr_addr_q <= wr_addr;
		end
		if (wr_data_valid && wr_data_ready) begin
			wr_data_q <= wr_data;
		end
		// Same-edge read of this address still sees the old word
		if (wr_commit) begin
			mem[wr_addr_q] <= wr_data_q;
		end
	end

	// Stalled word must not change under the consumer
	assert property (@(posedge clk) disable iff (!arst_n)
		(rd_data_valid && !rd_data_ready) |=> (rd_data_valid && $stable(rd_data)));

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
	input  logic                clk,
	input  logic                arst_n,

	// Host client
	input  nn_mem_pkg::rd_req_t host_rd,
	input  logic                host_rd_valid,
	output logic                host_rd_ready,
	output nn_mem_pkg::word_t   host_rd_data,
	output logic                host_rd_data_valid,
	input  logic                host_rd_data_ready,
	input  nn_mem_pkg::wr_req_t host_wr,
	input  logic                host_wr_valid,
	output logic                host_wr_ready,

	// Updater client
	input  nn_mem_pkg::rd_req_t upd_rd,
	input  logic                upd_rd_valid,
	output logic                upd_rd_ready,
	output nn_mem_pkg::word_t   upd_rd_data,
	output logic                upd_rd_data_valid,
	input  logic                upd_rd_data_ready,
	input  nn_mem_pkg::wr_req_t upd_wr,
	input  logic                upd_wr_valid,
	output logic                upd_wr_ready,

	// Memory side
	output nn_mem_pkg::rd_req_t mem_rd_addr,
	output logic                mem_rd_addr_valid,
	input  logic                mem_rd_addr_ready,
	input  nn_mem_pkg::word_t   mem_rd_data,
	input  logic                mem_rd_data_valid,
	output logic                mem_rd_data_ready,
	output nn_mem_pkg::addr_t   mem_wr_addr,
	output logic                mem_wr_addr_valid,
	input  logic                mem_wr_addr_ready,
	output nn_mem_pkg::word_t   mem_wr_data,
	output logic                mem_wr_data_valid,
	input  logic                mem_wr_data_ready
);

	nn_ctrl_pkg::client_t last;
	nn_ctrl_pkg::client_t rd_owner;
	logic                 lock;

	logic host_rd_req, host_wr_req;
	logic rd_gnt_upd, wr_gnt_upd;
	logic rd_fire, wr_fire, wr_room;
	nn_mem_pkg::wr_req_t wr_sel;

	////////////////////////////////////////////////////////////
	// Grants
	////////////////////////////////////////////////////////////

	// Host shut out during an update
	assign host_rd_req = host_rd_valid && !lock;
	assign host_wr_req = host_wr_valid && !lock;

	// Updater wins alone or when the host went last
	assign rd_gnt_upd = upd_rd_valid && (!host_rd_req || last == nn_ctrl_pkg::CLIENT_HOST);
	assign wr_gnt_upd = upd_wr_valid && (!host_wr_req || last == nn_ctrl_pkg::CLIENT_HOST);

	// Read address
	assign mem_rd_addr       = rd_gnt_upd ? upd_rd : host_rd;
	assign mem_rd_addr_valid = host_rd_req || upd_rd_valid;
	assign rd_fire           = mem_rd_addr_valid && mem_rd_addr_ready;
	assign upd_rd_ready      = rd_gnt_upd && mem_rd_addr_ready;
	assign host_rd_ready     = host_rd_req && !rd_gnt_upd && mem_rd_addr_ready;

	// Write, both halves offered together only when both can take them
	assign wr_room           = mem_wr_addr_ready && mem_wr_data_ready;
	assign wr_sel            = wr_gnt_upd ? upd_wr : host_wr;
	assign wr_fire           = (host_wr_req || upd_wr_valid) && wr_room;
	assign mem_wr_addr       = wr_sel.addr;
	assign mem_wr_data       = wr_sel.data;
	assign mem_wr_addr_valid = wr_fire;
	assign mem_wr_data_valid = wr_fire;
	assign upd_wr_ready      = wr_gnt_upd && wr_room;
	assign host_wr_ready     = host_wr_req && !wr_gnt_upd && wr_room;

	////////////////////////////////////////////////////////////
	// Response routing
	////////////////////////////////////////////////////////////

	assign host_rd_data       = mem_rd_data;
	assign upd_rd_data        = mem_rd_data;
	assign host_rd_data_valid = mem_rd_data_valid && rd_owner == nn_ctrl_pkg::CLIENT_HOST;
	assign upd_rd_data_valid  = mem_rd_data_valid && rd_owner == nn_ctrl_pkg::CLIENT_UPD;
	assign mem_rd_data_ready  = (rd_owner == nn_ctrl_pkg::CLIENT_UPD) ? upd_rd_data_ready
	                                                                  : host_rd_data_ready;

	// Round-robin history, read owner and update lock
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last     <= nn_ctrl_pkg::CLIENT_HOST;
			rd_owner <= nn_ctrl_pkg::CLIENT_HOST;
			lock     <= 1'b0;
		end else begin
			if (rd_fire) begin
				last     <= rd_gnt_upd ? nn_ctrl_pkg::CLIENT_UPD : nn_ctrl_pkg::CLIENT_HOST;
				rd_owner <= rd_gnt_upd ? nn_ctrl_pkg::CLIENT_UPD : nn_ctrl_pkg::CLIENT_HOST;
			end else if (wr_fire) begin
				last <= wr_gnt_upd ? nn_ctrl_pkg::CLIENT_UPD : nn_ctrl_pkg::CLIENT_HOST;
			end

			// Held from the updater read to its write
			if (upd_rd_valid && upd_rd_ready) begin
				lock <= 1'b1;
			end else if (upd_wr_valid && upd_wr_ready) begin
				lock <= 1'b0;
			end
		end
	end

	// No host grant for as long as the update holds the lock
	assert property (@(posedge clk) disable iff (!arst_n)
		lock |-> !(host_rd_ready || host_wr_ready));

endmodule

`default_nettype wire

// ==== logic/nn_ctrl_pkg.sv ====
`default_nettype none

package nn_ctrl_pkg;

	// Update delta, same width as a weight
	typedef logic signed [nn_mem_pkg::WORD_W-1:0] delta_t;

	// Update command, target weight and signed step
	typedef struct packed {
		nn_mem_pkg::addr_t addr;
		delta_t            delta;
	} upd_cmd_t;

	// Memory clients seen by the arbiter
	typedef enum logic [0:0] {
		CLIENT_HOST = 1'b0,
		CLIENT_UPD  = 1'b1
	} client_t;

	// Read-modify-write sequence of the updater
	typedef enum logic [1:0] {
		UPD_IDLE      = 2'd0,
		UPD_READ_REQ  = 2'd1,
		UPD_READ_WAIT = 2'd2,
		UPD_WRITE     = 2'd3
	} upd_state_t;

	// Saturation bounds of a signed word
	localparam nn_mem_pkg::word_t WORD_MAX = {1'b0, {(nn_mem_pkg::WORD_W-1){1'b1}}};
	localparam nn_mem_pkg::word_t WORD_MIN = {1'b1, {(nn_mem_pkg::WORD_W-1){1'b0}}};

endpackage

`default_nettype wire

// ==== logic/nn_mem_pkg.sv ====
`default_nettype none

package nn_mem_pkg;

	////////////////////////////////////////////////////////////
	// Memory geometry
	////////////////////////////////////////////////////////////

	// Weight address width, one word per address
	localparam int ADDR_W = 8;

	// Weight word width
	localparam int WORD_W = 32;

	// Number of stored weights
	localparam int DEPTH = 256;

	////////////////////////////////////////////////////////////
	// Base types
	////////////////////////////////////////////////////////////

	// Index into the weight memory
	typedef logic [ADDR_W-1:0] addr_t;

	// Stored weight, two's complement
	typedef logic signed [WORD_W-1:0] word_t;

	////////////////////////////////////////////////////////////
	// Channel payloads
	////////////////////////////////////////////////////////////

	// Read address channel payload
	typedef struct packed {
		addr_t addr;
	} rd_req_t;

	// Combined write request, address in the upper bits
	typedef struct packed {
		addr_t addr;
		word_t data;
	} wr_req_t;

endpackage

`default_nettype wire

// ==== logic/nn_weight_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module nn_weight_store (
	input  logic                  clk,
	input  logic                  arst_n,

	// Host read and write
	input  nn_mem_pkg::rd_req_t   host_rd,
	input  logic                  host_rd_valid,
	output logic                  host_rd_ready,
	output nn_mem_pkg::word_t     host_rd_data,
	output logic                  host_rd_data_valid,
	input  logic                  host_rd_data_ready,
	input  nn_mem_pkg::wr_req_t   host_wr,
	input  logic                  host_wr_valid,
	output logic                  host_wr_ready,

	// Update commands
	input  nn_ctrl_pkg::upd_cmd_t upd_cmd,
	input  logic                  upd_cmd_valid,
	output logic                  upd_cmd_ready,
	output logic                  upd_done
);

	////////////////////////////////////////////////////////////
	// Internal channels
	////////////////////////////////////////////////////////////

	// Updater to arbiter
	nn_mem_pkg::rd_req_t upd_rd;
	nn_mem_pkg::wr_req_t upd_wr;
	nn_mem_pkg::word_t   upd_rd_data;
	logic upd_rd_valid, upd_rd_ready, upd_rd_data_valid, upd_rd_data_ready;
	logic upd_wr_valid, upd_wr_ready;

	// Arbiter to memory
	nn_mem_pkg::rd_req_t mem_rd_addr;
	nn_mem_pkg::word_t   mem_rd_data;
	nn_mem_pkg::addr_t   mem_wr_addr;
	nn_mem_pkg::word_t   mem_wr_data;
	logic mem_rd_addr_valid, mem_rd_addr_ready, mem_rd_data_valid, mem_rd_data_ready;
	logic mem_wr_addr_valid, mem_wr_addr_ready, mem_wr_data_valid, mem_wr_data_ready;

	weight_updater i_weight_updater (
		.clk(clk), .arst_n(arst_n),
		.upd_cmd(upd_cmd), .upd_cmd_valid(upd_cmd_valid), .upd_cmd_ready(upd_cmd_ready),
		.upd_done(upd_done),
		.rd(upd_rd), .rd_valid(upd_rd_valid), .rd_ready(upd_rd_ready),
		.rd_data(upd_rd_data), .rd_data_valid(upd_rd_data_valid),
		.rd_data_ready(upd_rd_data_ready),
		.wr(upd_wr), .wr_valid(upd_wr_valid), .wr_ready(upd_wr_ready)
	);

	mem_arbiter i_mem_arbiter (
		.clk(clk), .arst_n(arst_n),
		.host_rd(host_rd), .host_rd_valid(host_rd_valid), .host_rd_ready(host_rd_ready),
		.host_rd_data(host_rd_data), .host_rd_data_valid(host_rd_data_valid),
		.host_rd_data_ready(host_rd_data_ready),
		.host_wr(host_wr), .host_wr_valid(host_wr_valid), .host_wr_ready(host_wr_ready),
		.upd_rd(upd_rd), .upd_rd_valid(upd_rd_valid), .upd_rd_ready(upd_rd_ready),
		.upd_rd_data(upd_rd_data), .upd_rd_data_valid(upd_rd_data_valid),
		.upd_rd_data_ready(upd_rd_data_ready),
		.upd_wr(upd_wr), .upd_wr_valid(upd_wr_valid), .upd_wr_ready(upd_wr_ready),
		.mem_rd_addr(mem_rd_addr), .mem_rd_addr_valid(mem_rd_addr_valid),
		.mem_rd_addr_ready(mem_rd_addr_ready),
		.mem_rd_data(mem_rd_data), .mem_rd_data_valid(mem_rd_data_valid),
		.mem_rd_data_ready(mem_rd_data_ready),
		.mem_wr_addr(mem_wr_addr), .mem_wr_addr_valid(mem_wr_addr_valid),
		.mem_wr_addr_ready(mem_wr_addr_ready),
		.mem_wr_data(mem_wr_data), .mem_wr_data_valid(mem_wr_data_valid),
		.mem_wr_data_ready(mem_wr_data_ready)
	);

	bram_wrapper i_bram_wrapper (
		.clk(clk), .arst_n(arst_n),
		.rd_addr(mem_rd_addr), .rd_addr_valid(mem_rd_addr_valid),
		.rd_addr_ready(mem_rd_addr_ready),
		.rd_data(mem_rd_data), .rd_data_valid(mem_rd_data_valid),
		.rd_data_ready(mem_rd_data_ready),
		.wr_addr(mem_wr_addr), .wr_addr_valid(mem_wr_addr_valid),
		.wr_addr_ready(mem_wr_addr_ready),
		.wr_data(mem_wr_data), .wr_data_valid(mem_wr_data_valid),
		.wr_data_ready(mem_wr_data_ready)
	);

endmodule

`default_nettype wire

// ==== logic/weight_updater.sv ====
`timescale 1ns/10ps
`default_nettype none

module weight_updater (
	input  logic                  clk,
	input  logic                  arst_n,

	// Command port
	input  nn_ctrl_pkg::upd_cmd_t upd_cmd,
	input  logic                  upd_cmd_valid,
	output logic                  upd_cmd_ready,
	output logic                  upd_done,

	// Read side toward the arbiter
	output nn_mem_pkg::rd_req_t   rd,
	output logic                  rd_valid,
	input  logic                  rd_ready,
	input  nn_mem_pkg::word_t     rd_data,
	input  logic                  rd_data_valid,
	output logic                  rd_data_ready,

	// Write side toward the arbiter
	output nn_mem_pkg::wr_req_t   wr,
	output logic                  wr_valid,
	input  logic                  wr_ready
);

	nn_ctrl_pkg::upd_state_t state;

	// Latched command and the result to write back
	nn_ctrl_pkg::upd_cmd_t cmd_q;
	nn_mem_pkg::word_t     result_q;
	logic                  done_q;

	////////////////////////////////////////////////////////////
	// Saturating add
	////////////////////////////////////////////////////////////

	// One guard bit catches signed overflow
	logic signed [nn_mem_pkg::WORD_W:0] sum_ext;
	nn_mem_pkg::word_t                  sum_sat;

	assign sum_ext = {rd_data[nn_mem_pkg::WORD_W-1], rd_data}
	               + {cmd_q.delta[nn_mem_pkg::WORD_W-1], cmd_q.delta};

	always_comb begin
		sum_sat = sum_ext[nn_mem_pkg::WORD_W-1:0];
		// Guard and sign disagree on overflow
		if (sum_ext[nn_mem_pkg::WORD_W] != sum_ext[nn_mem_pkg::WORD_W-1]) begin
			sum_sat = sum_ext[nn_mem_pkg::WORD_W] ? nn_ctrl_pkg::WORD_MIN
			                                      : nn_ctrl_pkg::WORD_MAX;
		end
	end

	////////////////////////////////////////////////////////////
	// Channel outputs
	////////////////////////////////////////////////////////////

	assign upd_cmd_ready = state == nn_ctrl_pkg::UPD_IDLE;
	assign rd_valid      = state == nn_ctrl_pkg::UPD_READ_REQ;
	assign rd_data_ready = state == nn_ctrl_pkg::UPD_READ_WAIT;
	assign wr_valid      = state == nn_ctrl_pkg::UPD_WRITE;
	assign rd.addr       = cmd_q.addr;
	assign wr.addr       = cmd_q.addr;
	assign wr.data       = result_q;
	assign upd_done      = done_q;

	// Sequence control
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= nn_ctrl_pkg::UPD_IDLE;
			done_q <= 1'b0;
		end else begin
			// Pulse in the cycle after the write is taken
			done_q <= wr_valid && wr_ready;
			case (state)
				nn_ctrl_pkg::UPD_IDLE: begin
					if (upd_cmd_valid) begin
						state <= nn_ctrl_pkg::UPD_READ_REQ;
					end
				end
				nn_ctrl_pkg::UPD_READ_REQ: begin
					if (rd_ready) begin
						state <= nn_ctrl_pkg::UPD_READ_WAIT;
					end
				end
				nn_ctrl_pkg::UPD_READ_WAIT: begin
					if (rd_data_valid) begin
						state <= nn_ctrl_pkg::UPD_WRITE;
					end
				end
				default: begin
					if (wr_ready) begin
						state <= nn_ctrl_pkg::UPD_IDLE;
					end
				end
			endcase
		end
	end

	// Command and result capture
	always_ff @(posedge clk) begin
		if (upd_cmd_valid && upd_cmd_ready) begin
			cmd_q <= upd_cmd;
		end
		if (rd_data_valid && rd_data_ready) begin
			result_q <= sum_sat;
		end
	end

	// Read data only shows up for the read in flight
	assert property (@(posedge clk) disable iff (!arst_n)
		rd_data_valid |-> state == nn_ctrl_pkg::UPD_READ_WAIT);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the weight store testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
	--top-module tb_nn_weight_store \
	-f src.f \
	-o vsim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/vsim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit "$status"
fi

exit 0

// ==== src.f ====
logic/nn_mem_pkg.sv
logic/nn_ctrl_pkg.sv
logic/bram_wrapper.sv
logic/mem_arbiter.sv
logic/weight_updater.sv
logic/nn_weight_store.sv
verification/tb_nn_weight_store.sv

// ==== verification/tb_nn_weight_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_nn_weight_store;

	// Cycle budget for all tests together, with margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk;
	logic arst_n;

	// Host channels
	nn_mem_pkg::rd_req_t   host_rd;
	logic                  host_rd_valid;
	logic                  host_rd_ready;
	nn_mem_pkg::word_t     host_rd_data;
	logic                  host_rd_data_valid;
	logic                  host_rd_data_ready;
	nn_mem_pkg::wr_req_t   host_wr;
	logic                  host_wr_valid;
	logic                  host_wr_ready;

	// Update channel
	nn_ctrl_pkg::upd_cmd_t upd_cmd;
	logic                  upd_cmd_valid;
	logic                  upd_cmd_ready;
	logic                  upd_done;

	// Expected memory contents
	nn_mem_pkg::word_t model [0:nn_mem_pkg::DEPTH-1];

	int done_count = 0;
	int cycles     = 0;

	nn_weight_store i_nn_weight_store (
		.clk(clk),
		.arst_n(arst_n),
		.host_rd(host_rd),
		.host_rd_valid(host_rd_valid),
		.host_rd_ready(host_rd_ready),
		.host_rd_data(host_rd_data),
		.host_rd_data_valid(host_rd_data_valid),
		.host_rd_data_ready(host_rd_data_ready),
		.host_wr(host_wr),
		.host_wr_valid(host_wr_valid),
		.host_wr_ready(host_wr_ready),
		.upd_cmd(upd_cmd),
		.upd_cmd_valid(upd_cmd_valid),
		.upd_cmd_ready(upd_cmd_ready),
		.upd_done(upd_done)
	);

	////////////////////////////////////////////////////////////
	// Clock, timeout and done counter
	////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1, "Simulation stopped on timeout");
		end
	end

	// Done is a registered pulse, stable at the falling edge
	always @(negedge clk) begin
		if (arst_n && upd_done) begin
			done_count <= done_count + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic report_error(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Signed add clamped to the 32-bit range
	function automatic nn_mem_pkg::word_t sat_add(input nn_mem_pkg::word_t base,
		input nn_ctrl_pkg::delta_t delta);
		longint full;
		full = longint'(base) + longint'(delta);
		if (full > 64'sd2147483647) begin
			return 32'h7fff_ffff;
		end
		if (full < -64'sd2147483648) begin
			return 32'h8000_0000;
		end
		return nn_mem_pkg::word_t'(full[31:0]);
	endfunction

	// Combined host write, model follows on acceptance
	task automatic write_word(input nn_mem_pkg::addr_t addr, input nn_mem_pkg::word_t data);
		@(negedge clk);
		host_wr.addr = addr;
		host_wr.data = data;
		host_wr_valid = 1'b1;
		#1;
		while (!host_wr_ready) begin
			@(negedge clk);
			#1;
		end
		model[addr] = data;
		@(negedge clk);
		host_wr_valid = 1'b0;
	endtask

	// Address handshake only
	task automatic issue_read(input nn_mem_pkg::addr_t addr);
		@(negedge clk);
		host_rd.addr = addr;
		host_rd_valid = 1'b1;
		#1;
		while (!host_rd_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		host_rd_valid = 1'b0;
	endtask

	task automatic check_read(input nn_mem_pkg::addr_t addr);
		nn_mem_pkg::word_t got;
		issue_read(addr);
		while (!host_rd_data_valid) begin
			@(negedge clk);
		end
		got = host_rd_data;
		assert (got === model[addr]) else begin
			report_error($sformatf("read of 0x%02h returned 0x%08h, expected 0x%08h",
				addr, got, model[addr]));
		end
	endtask

	task automatic send_update(input nn_mem_pkg::addr_t addr, input nn_ctrl_pkg::delta_t delta);
		@(negedge clk);
		upd_cmd.addr = addr;
		upd_cmd.delta = delta;
		upd_cmd_valid = 1'b1;
		#1;
		while (!upd_cmd_ready) begin
			@(negedge clk);
			#1;
		end
		model[addr] = sat_add(model[addr], delta);
		@(negedge clk);
		upd_cmd_valid = 1'b0;
	endtask

	task automatic wait_done(input int target);
		while (done_count < target) begin
			@(negedge clk);
			#1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic reset_state();
		repeat (4) begin
			#1;
			assert (!host_rd_ready && !host_rd_data_valid && !upd_done && upd_cmd_ready) else begin
				report_error("outputs not at their reset values after reset");
			end
			@(negedge clk);
		end
	endtask

	task automatic write_then_read();
		nn_mem_pkg::addr_t addr;
		for (int i = 0; i < 8; i++) begin
			addr = nn_mem_pkg::addr_t'(i * 3);
			write_word(addr, $urandom());
			check_read(addr);
		end
		// Overwrite one word, then read the whole set again
		write_word(8'h06, 32'h1234_5678);
		for (int i = 0; i < 8; i++) begin
			check_read(nn_mem_pkg::addr_t'(i * 3));
		end
	endtask

	task automatic read_backpressure();
		nn_mem_pkg::word_t held;
		write_word(8'h20, $urandom());
		write_word(8'h21, $urandom());
		@(negedge clk);
		host_rd_data_ready = 1'b0;
		issue_read(8'h20);
		while (!host_rd_data_valid) begin
			@(negedge clk);
		end
		held = host_rd_data;
		assert (held === model[8'h20]) else begin
			report_error($sformatf("stalled read returned 0x%08h, expected 0x%08h",
				held, model[8'h20]));
		end
		// Second read queued behind the stalled word
		host_rd.addr = 8'h21;
		host_rd_valid = 1'b1;
		repeat (8) begin
			#1;
			assert (host_rd_data_valid && host_rd_data === held) else begin
				report_error("stalled read data dropped or changed");
			end
			assert (!host_rd_ready) else begin
				report_error("host read address accepted while read data was stalled");
			end
			@(negedge clk);
		end
		host_rd_data_ready = 1'b1;
		#1;
		while (!host_rd_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		host_rd_valid = 1'b0;
		while (!host_rd_data_valid) begin
			@(negedge clk);
		end
		assert (host_rd_data === model[8'h21]) else begin
			report_error($sformatf("read after release returned 0x%08h, expected 0x%08h",
				host_rd_data, model[8'h21]));
		end
	endtask

	task automatic saturating_updates();
		nn_mem_pkg::addr_t   addrs  [4] = '{8'h30, 8'h31, 8'h32, 8'h33};
		nn_mem_pkg::word_t   bases  [4] = '{32'd1000, 32'h7fff_fff0, 32'h8000_0010, 32'h7fff_ff00};
		nn_ctrl_pkg::delta_t deltas [4] = '{-32'sd250, 32'sh100, -32'sh100, 32'sh0ff};
		// Ordinary, positive overflow, negative overflow, exact maximum
		for (int i = 0; i < 4; i++) begin
			write_word(addrs[i], bases[i]);
			send_update(addrs[i], deltas[i]);
			wait_done(done_count + 1);
			check_read(addrs[i]);
		end
		// Second step on the same weight
		send_update(8'h30, -32'sd2000);
		wait_done(done_count + 1);
		check_read(8'h30);
	endtask

	task automatic concurrent_traffic();
		nn_mem_pkg::addr_t touched [$];
		int                start;
		// Known starting values for the update targets
		for (int j = 0; j < 10; j++) begin
			write_word(nn_mem_pkg::addr_t'(8'hC0 + j), $urandom());
			touched.push_back(nn_mem_pkg::addr_t'(8'hC0 + j));
		end
		start = done_count;
		fork
			begin
				for (int i = 0; i < 16; i++) begin
					repeat ($urandom_range(3)) @(negedge clk);
					write_word(nn_mem_pkg::addr_t'(8'h40 + i * 3), $urandom());
					touched.push_back(nn_mem_pkg::addr_t'(8'h40 + i * 3));
				end
			end
			begin
				for (int j = 0; j < 10; j++) begin
					send_update(nn_mem_pkg::addr_t'(8'hC0 + j), nn_ctrl_pkg::delta_t'($urandom()));
				end
			end
		join
		wait_done(start + 10);
		repeat (4) @(negedge clk);
		#1;
		assert (done_count == start + 10) else begin
			report_error($sformatf("saw %0d done pulses for 10 update commands", done_count - start));
		end
		foreach (touched[k]) begin
			check_read(touched[k]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial begin
		arst_n             = 1'b0;
		host_rd            = '0;
		host_rd_valid      = 1'b0;
		host_rd_data_ready = 1'b1;
		host_wr            = '0;
		host_wr_valid      = 1'b0;
		upd_cmd            = '0;
		upd_cmd_valid      = 1'b0;
		void'($urandom(32'h547));
		repeat (10) @(negedge clk);
		arst_n = 1'b1;
		reset_state();
		write_then_read();
		read_backpressure();
		saturating_updates();
		concurrent_traffic();
		repeat (5) @(negedge clk);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
